//--- rtl/irq_pkg.sv
package irq_pkg;

   // Interrupt sources
   // VBLANK, LCDC, TIMER, SERIAL, JOYPAD
   localparam int NUM_IRQ = 5;

   // Memory-mapped bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // Winning index width
   // Holds 0 to NUM_IRQ-1
   localparam int IRQ_IDX_W = 3;

   // Register map
   // IF sits in the I/O page, IE at the very top of memory
   localparam logic [ADDR_W-1:0] ADDR_IF = 16'hff0f;
   localparam logic [ADDR_W-1:0] ADDR_IE = 16'hffff;

   // Jump vectors
   // First vector at 0x40
   localparam logic [DATA_W-1:0] VEC_BASE = 8'h40;

   // Vectors eight bytes apart
   localparam int VEC_STEP_SHIFT = 3;

   // Master enable after reset
   // Set out of reset, so interrupts are live once enabled
   localparam logic IME_RESET_VAL = 1'b1;

   // Source bit positions in IF and IE
   // Lower index means higher priority
   localparam int IRQ_VBLANK = 0;

   // LCD status
   localparam int IRQ_LCDC = 1;

   // Timer overflow
   localparam int IRQ_TIMER = 2;

   // Serial transfer done
   localparam int IRQ_SERIAL = 3;

   // Joypad edge
   localparam int IRQ_JOYPAD = 4;

   // Largest vector is VEC_BASE + (NUM_IRQ-1) * 8, i.e. 0x60
   // Still fits in one byte with room to spare

   // Register read-back pads the top DATA_W - NUM_IRQ bits with zero

endpackage

//--- rtl/irq_priority.sv
`timescale 1ns/1ps

module irq_priority
   import irq_pkg::*;
(
   input  logic               clock,
   input  logic               reset,

   // Masked requests from the slices
   input  logic [NUM_IRQ-1:0] pending,

   // CPU accepts the current winner
   input  logic               ack,

   // Master enable strobes
   // EI and DI style, never together
   input  logic               ime_set,
   input  logic               ime_reset,

   // Per-slice flag clear on acknowledge
   output logic [NUM_IRQ-1:0] clear,

   // Interrupt request to the core
   output logic               irq_req,

   // Jump address low byte
   output logic [DATA_W-1:0]  irq_vector
);

   // Encoder results
   logic                 any_pending;
   logic [IRQ_IDX_W-1:0] win_idx;
   logic [NUM_IRQ-1:0]   win_onehot;

   // Master enable flop
   logic                 ime;

   // Something enabled is waiting
   assign any_pending = |pending;

   // Lowest index wins
   // Scan from the top so the lowest set bit is written last
   always_comb begin
      // Idle default points at VBLANK
      win_idx = IRQ_IDX_W'(IRQ_VBLANK);
      for (int i = NUM_IRQ - 1; i >= 0; i--) begin
         if (pending[i]) begin
            win_idx = IRQ_IDX_W'(i);
         end
      end
   end

   // One-hot of the winner
   // Zero when idle
   always_comb begin
      win_onehot = '0;
      if (any_pending) begin
         win_onehot[win_idx] = 1'b1;
      end
   end

   // Clear only the winner, only on ack
   // Ack with nothing pending does nothing
   assign clear = ack ? win_onehot : '0;

   // Vector is base plus index times eight
   // Idle index of zero leaves it at the base
   assign irq_vector = VEC_BASE + (DATA_W'(win_idx) << VEC_STEP_SHIFT);

   // IME register
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ime <= IME_RESET_VAL;
      end else if (ime_set) begin
         ime <= 1'b1;
      end else if (ime_reset) begin
         ime <= 1'b0;
      end
   end

   // Request is gated by IME only
   // Pending already carries the IE mask
   assign irq_req = ime && any_pending;

   // Set and reset strobes are exclusive
   assert property (@(posedge clock) disable iff (reset) !(ime_set && ime_reset))
      else $error("ime_set and ime_reset high together");

endmodule

//--- rtl/irq_reg_decode.sv
`timescale 1ns/1ps

module irq_reg_decode
   import irq_pkg::*;
(
   // Bus side
   input  logic [ADDR_W-1:0]  bus_addr,
   input  logic               bus_wr,
   input  logic [DATA_W-1:0]  bus_wdata,

   // Register contents gathered from the slices
   input  logic [NUM_IRQ-1:0] if_bits,
   input  logic [NUM_IRQ-1:0] ie_bits,

   // Shared write strobes and data to the slices
   output logic               if_wr,
   output logic               ie_wr,
   output logic [NUM_IRQ-1:0] wr_bits,

   // Read-back, combinational from address
   output logic [DATA_W-1:0]  bus_rdata
);

   // Address hits
   logic sel_if;
   logic sel_ie;

   // Full 16-bit compare
   assign sel_if = (bus_addr == ADDR_IF);
   assign sel_ie = (bus_addr == ADDR_IE);

   // Write enables
   // Strobe and address valid in the same cycle
   assign if_wr = bus_wr && sel_if;
   assign ie_wr = bus_wr && sel_ie;

   // Only the low bits are backed by flops
   // Upper data bits are dropped on write
   assign wr_bits = bus_wdata[NUM_IRQ-1:0];

   // Read mux
   always_comb begin
      // Unmapped address reads zero
      bus_rdata = '0;
      if (sel_if) begin
         // IF with upper bits zero
         bus_rdata[NUM_IRQ-1:0] = if_bits;
      end else if (sel_ie) begin
         // IE with upper bits zero
         bus_rdata[NUM_IRQ-1:0] = ie_bits;
      end
   end

endmodule

//--- rtl/irq_source.sv
`timescale 1ns/1ps

module irq_source (
   input  logic clock,
   input  logic reset,

   // Request pulse from the peripheral
   input  logic irq,

   // Register writes from the decoder
   input  logic if_wr,
   input  logic ie_wr,
   input  logic wr_bit,

   // Acknowledge clear from the priority encoder
   input  logic clear,

   // State for read-back
   output logic flag,
   output logic enable,

   // Flag and enable both set
   output logic pending
);

   // Flag bit
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         flag <= 1'b0;
      end else if (irq) begin
         // Request beats a write of zero and an ack
         flag <= 1'b1;
      end else if (if_wr) begin
         // Software may set or clear the flag
         flag <= wr_bit;
      end else if (clear) begin
         // Serviced
         flag <= 1'b0;
      end
   end

   // Enable bit, written only through IE
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         enable <= 1'b0;
      end else if (ie_wr) begin
         enable <= wr_bit;
      end
   end

   // Masked request toward the encoder
   assign pending = flag && enable;

   // Encoder only clears a source that it saw pending
   assert property (@(posedge clock) disable iff (reset) clear |-> pending)
      else $error("clear on a source that is not pending");

endmodule

//--- rtl/irq_unit.sv
`timescale 1ns/1ps

module irq_unit
   import irq_pkg::*;
(
   input  logic               clock,
   input  logic               reset,

   // Register access port
   input  logic [ADDR_W-1:0]  bus_addr,
   input  logic               bus_wr,
   input  logic [DATA_W-1:0]  bus_wdata,
   output logic [DATA_W-1:0]  bus_rdata,

   // Peripheral request pulses
   input  logic [NUM_IRQ-1:0] irq,

   // Core side
   input  logic               ack,
   input  logic               ime_set,
   input  logic               ime_reset,
   output logic               irq_req,
   output logic [DATA_W-1:0]  irq_vector
);

   // Decoder to slices
   logic               if_wr;
   logic               ie_wr;
   logic [NUM_IRQ-1:0] wr_bits;

   // Slices back to decoder
   logic [NUM_IRQ-1:0] if_bits;
   logic [NUM_IRQ-1:0] ie_bits;

   // Slices to and from the encoder
   logic [NUM_IRQ-1:0] pending;
   logic [NUM_IRQ-1:0] clear;

   // Bus decode and read-back
   irq_reg_decode i_decode (
      .bus_addr  (bus_addr),
      .bus_wr    (bus_wr),
      .bus_wdata (bus_wdata),
      .if_bits   (if_bits),
      .ie_bits   (ie_bits),
      .if_wr     (if_wr),
      .ie_wr     (ie_wr),
      .wr_bits   (wr_bits),
      .bus_rdata (bus_rdata)
   );

   // One slice per source
   // Bit i of IF and IE lives in slice i
   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_source
      irq_source i_source (
         .clock   (clock),
         .reset   (reset),
         .irq     (irq[i]),
         .if_wr   (if_wr),
         .ie_wr   (ie_wr),
         .wr_bit  (wr_bits[i]),
         .clear   (clear[i]),
         .flag    (if_bits[i]),
         .enable  (ie_bits[i]),
         .pending (pending[i])
      );
   end

   // Winner select, vector and IME
   irq_priority i_priority (
      .clock      (clock),
      .reset      (reset),
      .pending    (pending),
      .ack        (ack),
      .ime_set    (ime_set),
      .ime_reset  (ime_reset),
      .clear      (clear),
      .irq_req    (irq_req),
      .irq_vector (irq_vector)
   );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the interrupt unit testbench with Verilator
# Exit status follows the testbench result

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

# Package, RTL and testbench into one binary, then run it into the log
verilator --binary --timing --assert -f sim.f --top-module tb_irq_unit -o tb_irq_unit \
   && ./obj_dir/tb_irq_unit > sim.log 2>&1

# Show the run
[ -f sim.log ] && cat sim.log

# Result comes from the log alone
grep -q "STATUS: PASS" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- sim.f
rtl/irq_pkg.sv
rtl/irq_reg_decode.sv
rtl/irq_source.sv
rtl/irq_priority.sv
rtl/irq_unit.sv
verif/tb_irq_unit.sv

//--- verif/tb_irq_unit.sv
`timescale 1ns/1ps

module tb_irq_unit
   import irq_pkg::*;
;

   // Run length
   localparam int CLOCK_PERIOD = 10;
   localparam int RESET_CYCLES = 4;
   localparam int NUM_DIRECTED = 40;
   localparam int NUM_RANDOM   = 3000;
   localparam int NUM_CYCLES   = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM;

   // DUT signals
   logic               clock = 1'b0;
   logic               reset;
   logic [ADDR_W-1:0]  bus_addr;
   logic               bus_wr;
   logic [DATA_W-1:0]  bus_wdata;
   logic [DATA_W-1:0]  bus_rdata;
   logic [NUM_IRQ-1:0] irq;
   logic               ack;
   logic               ime_set;
   logic               ime_reset;
   logic               irq_req;
   logic [DATA_W-1:0]  irq_vector;

   // Reference model state
   logic [NUM_IRQ-1:0] m_if;
   logic [NUM_IRQ-1:0] m_ie;
   logic               m_ime;

   // Bookkeeping
   integer seed;
   int     checks = 0;
   int     errors = 0;

   irq_unit i_dut (
      .clock      (clock),
      .reset      (reset),
      .bus_addr   (bus_addr),
      .bus_wr     (bus_wr),
      .bus_wdata  (bus_wdata),
      .bus_rdata  (bus_rdata),
      .irq        (irq),
      .ack        (ack),
      .ime_set    (ime_set),
      .ime_reset  (ime_reset),
      .irq_req    (irq_req),
      .irq_vector (irq_vector)
   );

   always #(CLOCK_PERIOD / 2) clock = ~clock;

   // Index of the lowest set bit, or -1 when none
   function automatic int lowest_pending(input logic [NUM_IRQ-1:0] pend);
      int idx;
      idx = -1;
      for (int i = 0; i < NUM_IRQ; i++) begin
         if (pend[i] && idx < 0) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   // Expected {irq_req, irq_vector, bus_rdata} from model state and address
   function automatic logic [2*DATA_W:0] expected_outputs(
      input logic [NUM_IRQ-1:0] flags,
      input logic [NUM_IRQ-1:0] enables,
      input logic               master,
      input logic [ADDR_W-1:0]  addr
   );
      int                idx;
      logic              req;
      logic [DATA_W-1:0] vec;
      logic [DATA_W-1:0] rdata;
      idx = lowest_pending(flags & enables);
      req = master && (idx >= 0);
      // Vectors eight bytes apart from the base
      vec = VEC_BASE;
      if (idx >= 0) begin
         vec = VEC_BASE + DATA_W'(idx * 8);
      end
      // Zero-extended read-back, zero when unmapped
      rdata = '0;
      if (addr == ADDR_IF) begin
         rdata = {{(DATA_W - NUM_IRQ){1'b0}}, flags};
      end else if (addr == ADDR_IE) begin
         rdata = {{(DATA_W - NUM_IRQ){1'b0}}, enables};
      end
      return {req, vec, rdata};
   endfunction

   // Model registers step on the same edge as the DUT
   always @(posedge clock or posedge reset) begin : model_update
      int                 win;
      logic [NUM_IRQ-1:0] next_if;
      if (reset) begin
         m_if  <= '0;
         m_ie  <= '0;
         m_ime <= 1'b1;
      end else begin
         win     = lowest_pending(m_if & m_ie);
         next_if = m_if;
         for (int i = 0; i < NUM_IRQ; i++) begin
            // Request first, then write, then ack of the winner
            if (irq[i]) begin
               next_if[i] = 1'b1;
            end else if (bus_wr && bus_addr == ADDR_IF) begin
               next_if[i] = bus_wdata[i];
            end else if (ack && win == i) begin
               next_if[i] = 1'b0;
            end
         end
         m_if <= next_if;
         if (bus_wr && bus_addr == ADDR_IE) begin
            m_ie <= bus_wdata[NUM_IRQ-1:0];
         end
         if (ime_set) begin
            m_ime <= 1'b1;
         end else if (ime_reset) begin
            m_ime <= 1'b0;
         end
      end
   end

   // Compare once both sides have settled after the edge
   always @(posedge clock) begin : compare_outputs
      logic [2*DATA_W:0] exp;
      #1;
      if (!reset) begin
         exp    = expected_outputs(m_if, m_ie, m_ime, bus_addr);
         checks = checks + 3;
         if (irq_req !== exp[2*DATA_W]) begin
            $display("[ERROR] %0d ns: irq_req is %b, expected %b",
                     $time, irq_req, exp[2*DATA_W]);
            errors++;
         end
         if (irq_vector !== exp[2*DATA_W-1:DATA_W]) begin
            $display("[ERROR] %0d ns: irq_vector is %h, expected %h",
                     $time, irq_vector, exp[2*DATA_W-1:DATA_W]);
            errors++;
         end
         if (bus_rdata !== exp[DATA_W-1:0]) begin
            $display("[ERROR] %0d ns: bus_rdata at %h is %h, expected %h",
                     $time, bus_addr, bus_rdata, exp[DATA_W-1:0]);
            errors++;
         end
      end
   end

   // One cycle of inputs, applied on the falling edge
   task automatic drive(
      input logic [ADDR_W-1:0]  addr,
      input logic               wr,
      input logic [DATA_W-1:0]  wdata,
      input logic [NUM_IRQ-1:0] req,
      input logic               ack_v,
      input logic               set_v,
      input logic               clr_v
   );
      @(negedge clock);
      bus_addr  = addr;
      bus_wr    = wr;
      bus_wdata = wdata;
      irq       = req;
      ack       = ack_v;
      ime_set   = set_v;
      ime_reset = clr_v;
   endtask

   // Read-only cycle
   task automatic idle(input logic [ADDR_W-1:0] addr);
      drive(addr, 1'b0, 8'h00, 5'b00000, 1'b0, 1'b0, 1'b0);
   endtask

   // Literal check of the outputs, called just after a drive
   // Sees the state left by the cycle before that drive
   task automatic expect_state(
      input logic              exp_req,
      input logic [DATA_W-1:0] exp_vec,
      input string             what
   );
      checks++;
      if (irq_req !== exp_req || irq_vector !== exp_vec) begin
         $display("[ERROR] %0d ns: %s gives irq_req %b vector %h, expected %b %h",
                  $time, what, irq_req, irq_vector, exp_req, exp_vec);
         errors++;
      end
   endtask

   // Sparse requests, rare writes and acks, exclusive IME strobes
   task automatic random_cycle();
      integer             r;
      logic [ADDR_W-1:0]  addr;
      logic [NUM_IRQ-1:0] req;
      logic               wr;
      logic               set_v;
      logic               clr_v;
      r = $random(seed);
      case (r[1:0])
         2'd0:    addr = ADDR_IF;
         2'd1:    addr = ADDR_IE;
         default: addr = r[31:16];
      endcase
      wr = (r[4:2] == 3'd0);
      req = '0;
      r = $random(seed);
      for (int i = 0; i < NUM_IRQ; i++) begin
         if (r[4*i +: 4] == 4'd0) begin
            req[i] = 1'b1;
         end
      end
      set_v = (r[27:24] == 4'd0);
      clr_v = (r[27:24] == 4'd1);
      drive(addr, wr, r[31:24] ^ r[7:0], req, r[22:20] == 3'd0, set_v, clr_v);
   endtask

   initial begin
      seed      = 32'hadcf_b036;
      reset     = 1'b1;
      bus_addr  = ADDR_IF;
      bus_wr    = 1'b0;
      bus_wdata = '0;
      irq       = '0;
      ack       = 1'b0;
      ime_set   = 1'b0;
      ime_reset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;

      // Out of reset
      idle(ADDR_IF);
      expect_state(1'b0, 8'h40, "after reset");
      idle(ADDR_IE);

      // Read-back with upper bits dropped
      drive(ADDR_IF, 1'b1, 8'hff, 5'b00000, 1'b0, 1'b0, 1'b0);
      idle(ADDR_IF);
      drive(ADDR_IE, 1'b1, 8'he5, 5'b00000, 1'b0, 1'b0, 1'b0);
      idle(ADDR_IE);
      // Unmapped address next to IF
      drive(16'hff0e, 1'b1, 8'hff, 5'b00000, 1'b0, 1'b0, 1'b0);
      idle(16'hff0e);
      idle(ADDR_IF);
      idle(ADDR_IE);
      drive(ADDR_IF, 1'b1, 8'h00, 5'b00000, 1'b0, 1'b0, 1'b0);
      drive(ADDR_IE, 1'b1, 8'h00, 5'b00000, 1'b0, 1'b0, 1'b0);

      // Timer request against an IF write of zero
      drive(ADDR_IE, 1'b1, 8'h04, 5'b00000, 1'b0, 1'b0, 1'b0);
      drive(ADDR_IF, 1'b1, 8'h00, 5'b00100, 1'b0, 1'b0, 1'b0);
      idle(ADDR_IF);
      expect_state(1'b1, 8'h50, "timer request");

      // Several pending, acked one at a time
      drive(ADDR_IE, 1'b1, 8'h1f, 5'b00000, 1'b0, 1'b0, 1'b0);
      drive(ADDR_IF, 1'b0, 8'h00, 5'b11010, 1'b0, 1'b0, 1'b0);
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00000, 1'b1, 1'b0, 1'b0);
      expect_state(1'b1, 8'h48, "LCDC wins");
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00000, 1'b1, 1'b0, 1'b0);
      expect_state(1'b1, 8'h50, "timer wins");
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00000, 1'b1, 1'b0, 1'b0);
      expect_state(1'b1, 8'h58, "serial wins");
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00000, 1'b1, 1'b0, 1'b0);
      expect_state(1'b1, 8'h60, "joypad wins");
      idle(ADDR_IF);
      expect_state(1'b0, 8'h40, "all acked");

      // Master enable gating
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00011, 1'b0, 1'b0, 1'b0);
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00000, 1'b0, 1'b0, 1'b1);
      expect_state(1'b1, 8'h40, "VBLANK pending");
      idle(ADDR_IF);
      expect_state(1'b0, 8'h40, "IME off");
      idle(ADDR_IF);
      expect_state(1'b0, 8'h40, "IME still off");
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00000, 1'b0, 1'b1, 1'b0);
      expect_state(1'b0, 8'h40, "IME set pending");
      idle(ADDR_IF);
      expect_state(1'b1, 8'h40, "IME back on");

      // Ack with flags raised but all masked
      // VBLANK and LCDC flags must survive it
      drive(ADDR_IE, 1'b1, 8'h00, 5'b00000, 1'b0, 1'b0, 1'b0);
      drive(ADDR_IF, 1'b0, 8'h00, 5'b00000, 1'b1, 1'b0, 1'b0);
      expect_state(1'b0, 8'h40, "flags masked");
      idle(ADDR_IF);
      expect_state(1'b0, 8'h40, "idle ack");
      drive(ADDR_IE, 1'b1, 8'h03, 5'b00000, 1'b0, 1'b0, 1'b0);
      idle(ADDR_IF);
      expect_state(1'b1, 8'h40, "flags kept");

      // Long random run
      repeat (NUM_RANDOM) random_cycle();
      idle(ADDR_IF);
      @(posedge clock);
      #2;

      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog sized from the run length
   initial begin
      #((NUM_CYCLES + 20) * CLOCK_PERIOD);
      $display("Watchdog expired: the test did not finish in time");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule
